//--- design/msx_slots_pkg.sv
package msx_slots_pkg;

	// CPU side bus
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// ASCII8 bank register contents
	typedef logic [7:0]  bank_t;

	// External ROM memory byte address
	// Bit 21 selects the cartridge slot, 20..13 the bank, 12..0 the offset in the page
	typedef logic [21:0] mem_addr_t;

	// Cartridge mapper types
	typedef enum logic [1:0] {
		mapper_plain  = 2'd0,
		mapper_ascii8 = 2'd1
	} mapper_e;

	// Cartridge memory fetch
	typedef enum logic [1:0] {
		fetch_idle         = 2'd0,
		fetch_req          = 2'd1,
		fetch_wait_ack_low = 2'd2,
		fetch_hold         = 2'd3
	} fetch_state_e;

	// Current owner of the shared memory port
	typedef enum logic [1:0] {
		route_free   = 2'd0,
		route_slot_a = 2'd1,
		route_slot_b = 2'd2
	} route_state_e;

endpackage

//--- design/slot_config.sv
`timescale 1ns/1ns

module slot_config (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     cfg_wr,
	input  logic [1:0]               cfg_addr,
	input  msx_slots_pkg::cpu_data_t cfg_data,
	output msx_slots_pkg::mapper_e   mapper_a,
	output msx_slots_pkg::mapper_e   mapper_b,
	output logic                     rom_en_a,
	output logic                     rom_en_b
);

	logic mapper_ok;

	// Only codes that name a known mapper are taken
	assign mapper_ok = (cfg_data[7:2] == 6'd0) &&
		(cfg_data[1:0] inside {msx_slots_pkg::mapper_plain, msx_slots_pkg::mapper_ascii8});

	always_ff @(posedge clk) begin
		if (rst) begin
			mapper_a <= msx_slots_pkg::mapper_plain;
			mapper_b <= msx_slots_pkg::mapper_plain;
			rom_en_a <= 1'b1;
			rom_en_b <= 1'b1;
		end else if (cfg_wr) begin
			case (cfg_addr)
				2'd0: begin
					if (mapper_ok)
						mapper_a <= msx_slots_pkg::mapper_e'(cfg_data[1:0]);
				end
				2'd1: begin
					if (mapper_ok)
						mapper_b <= msx_slots_pkg::mapper_e'(cfg_data[1:0]);
				end
				2'd2: begin
					rom_en_a <= cfg_data[0];
					rom_en_b <= cfg_data[1];
				end
				default: begin
					// Address 3 is unused
				end
			endcase
		end
	end

endmodule

//--- design/cart_mapper.sv
`timescale 1ns/1ns

module cart_mapper (
	input  logic                     clk,
	input  logic                     clk_en,
	input  logic                     rst,
	input  msx_slots_pkg::cpu_addr_t addr,
	input  msx_slots_pkg::cpu_data_t d_from_cpu,
	input  logic                     rd_n,
	input  logic                     wr_n,
	input  logic                     sltsl_n,
	input  msx_slots_pkg::mapper_e   mapper,
	input  logic                     rom_en,
	output msx_slots_pkg::cpu_data_t d_to_cpu,
	output logic                     wait_req,
	output logic                     req,
	output logic [20:0]              req_addr,
	input  logic                     ack,
	input  msx_slots_pkg::cpu_data_t data
);

	msx_slots_pkg::fetch_state_e state;
	msx_slots_pkg::bank_t        bank_regs [4];
	msx_slots_pkg::bank_t        bank;
	msx_slots_pkg::cpu_data_t    rd_data;
	logic [14:0]                 offset;
	logic                        in_range;
	logic                        bank_wr;
	logic                        rd_n_q;
	logic                        read_start;

	// Cartridge window 0x4000 to 0xBFFF
	assign in_range = (addr[15:14] == 2'b01) || (addr[15:14] == 2'b10);
	assign offset   = addr[14:0] - 15'h4000;

	// Page 0 is 0x4000, so offset bits 14..13 give the page index
	always_comb begin
		if (mapper == msx_slots_pkg::mapper_ascii8)
			bank = bank_regs[offset[14:13]];
		else
			bank = {6'd0, offset[14:13]};
	end

	// ASCII8 bank select window 0x6000 to 0x7FFF
	assign bank_wr = clk_en && !wr_n && !sltsl_n &&
		(mapper == msx_slots_pkg::mapper_ascii8) && (addr[15:13] == 3'b011);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 4; i++)
				bank_regs[i] <= msx_slots_pkg::bank_t'(i);
		end else if (bank_wr) begin
			bank_regs[addr[12:11]] <= d_from_cpu;
		end
	end

	// Falling rd_n seen on the CPU clock enable
	always_ff @(posedge clk) begin
		if (rst)
			rd_n_q <= 1'b1;
		else if (clk_en)
			rd_n_q <= rd_n;
	end

	assign read_start = clk_en && rd_n_q && !rd_n && !sltsl_n && rom_en && in_range;

	// Handshake side runs every clk
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= msx_slots_pkg::fetch_idle;
		end else begin
			case (state)
				msx_slots_pkg::fetch_idle: begin
					if (read_start)
						state <= msx_slots_pkg::fetch_req;
				end
				msx_slots_pkg::fetch_req: begin
					if (ack)
						state <= msx_slots_pkg::fetch_wait_ack_low;
				end
				msx_slots_pkg::fetch_wait_ack_low: begin
					if (!ack)
						state <= msx_slots_pkg::fetch_hold;
				end
				msx_slots_pkg::fetch_hold: begin
					// Byte stays on the bus until the CPU ends the read
					if (clk_en && rd_n)
						state <= msx_slots_pkg::fetch_idle;
				end
				default: begin
					state <= msx_slots_pkg::fetch_idle;
				end
			endcase
		end
	end

	// Address is frozen for the whole request
	always_ff @(posedge clk) begin
		if (read_start)
			req_addr <= {bank, addr[12:0]};
		if ((state == msx_slots_pkg::fetch_req) && ack)
			rd_data <= data;
	end

	assign req      = (state == msx_slots_pkg::fetch_req);
	assign wait_req = (state == msx_slots_pkg::fetch_req) ||
		(state == msx_slots_pkg::fetch_wait_ack_low);

	// Unmapped or disabled reads float high
	assign d_to_cpu = (rom_en && in_range) ? rd_data : 8'hFF;

endmodule

//--- design/slot_router.sv
`timescale 1ns/1ns

module slot_router (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [3:0]               sltsl_n,
	input  msx_slots_pkg::cpu_data_t d_a,
	input  msx_slots_pkg::cpu_data_t d_b,
	input  msx_slots_pkg::cpu_data_t d_ram,
	input  logic                     wait_a,
	input  logic                     wait_b,
	input  logic                     req_a,
	input  logic                     req_b,
	input  logic [20:0]              req_addr_a,
	input  logic [20:0]              req_addr_b,
	output logic                     ack_a,
	output logic                     ack_b,
	output logic                     mem_req,
	output msx_slots_pkg::mem_addr_t mem_addr,
	input  logic                     mem_ack,
	output msx_slots_pkg::cpu_data_t d_to_cpu,
	output logic                     cpu_wait
);

	msx_slots_pkg::route_state_e state;
	msx_slots_pkg::route_state_e owner;

	// Slot 0 and no selection both read as 0xFF
	always_comb begin
		if (!sltsl_n[1])
			d_to_cpu = d_a;
		else if (!sltsl_n[2])
			d_to_cpu = d_b;
		else if (!sltsl_n[3])
			d_to_cpu = d_ram;
		else
			d_to_cpu = 8'hFF;
	end

	assign cpu_wait = wait_a | wait_b;

	// A free port is handed over in the same cycle, slot 1 first
	always_comb begin
		owner = state;
		if (state == msx_slots_pkg::route_free) begin
			if (req_a)
				owner = msx_slots_pkg::route_slot_a;
			else if (req_b)
				owner = msx_slots_pkg::route_slot_b;
		end
	end

	always_comb begin
		case (owner)
			msx_slots_pkg::route_slot_a: mem_req = req_a;
			msx_slots_pkg::route_slot_b: mem_req = req_b;
			default:                     mem_req = 1'b0;
		endcase
	end

	assign mem_addr = (owner == msx_slots_pkg::route_slot_b) ?
		{1'b1, req_addr_b} : {1'b0, req_addr_a};

	assign ack_a = (owner == msx_slots_pkg::route_slot_a) && mem_ack;
	assign ack_b = (owner == msx_slots_pkg::route_slot_b) && mem_ack;

	// Owner held until the handshake is back to idle
	always_ff @(posedge clk) begin
		if (rst)
			state <= msx_slots_pkg::route_free;
		else if (state == msx_slots_pkg::route_free)
			state <= owner;
		else if (!mem_req && !mem_ack)
			state <= msx_slots_pkg::route_free;
	end

endmodule

//--- design/main_ram.sv
`timescale 1ns/1ns

module main_ram #(
	parameter int ram_addr_width = 16
) (
	input  logic                     clk,
	input  logic                     clk_en,
	input  msx_slots_pkg::cpu_addr_t addr,
	input  msx_slots_pkg::cpu_data_t d_from_cpu,
	input  logic                     we,
	output msx_slots_pkg::cpu_data_t q
);

	msx_slots_pkg::cpu_data_t  mem [2**ram_addr_width];
	logic [ram_addr_width-1:0] word_addr;

	// Smaller RAMs wrap inside the 64 kB slot
	assign word_addr = addr[ram_addr_width-1:0];

	// Old byte is returned on a write cycle
	always_ff @(posedge clk) begin
		if (clk_en) begin
			if (we)
				mem[word_addr] <= d_from_cpu;
			q <= mem[word_addr];
		end
	end

endmodule

//--- design/msx_slots.sv
`timescale 1ns/1ns

module msx_slots #(
	parameter int ram_addr_width = 16
) (
	input  logic                     clk,
	input  logic                     clk_en,
	input  logic                     rst,
	input  msx_slots_pkg::cpu_addr_t addr,
	input  msx_slots_pkg::cpu_data_t d_from_cpu,
	input  logic                     rd_n,
	input  logic                     wr_n,
	input  logic [3:0]               sltsl_n,
	output msx_slots_pkg::cpu_data_t d_to_cpu,
	output logic                     cpu_wait,
	input  logic                     cfg_wr,
	input  logic [1:0]               cfg_addr,
	input  msx_slots_pkg::cpu_data_t cfg_data,
	output logic                     mem_req,
	output msx_slots_pkg::mem_addr_t mem_addr,
	input  logic                     mem_ack,
	input  msx_slots_pkg::cpu_data_t mem_data
);

	msx_slots_pkg::mapper_e   mapper_a;
	msx_slots_pkg::mapper_e   mapper_b;
	logic                     rom_en_a;
	logic                     rom_en_b;
	msx_slots_pkg::cpu_data_t d_a;
	msx_slots_pkg::cpu_data_t d_b;
	msx_slots_pkg::cpu_data_t d_ram;
	logic                     wait_a;
	logic                     wait_b;
	logic                     req_a;
	logic                     req_b;
	logic [20:0]              req_addr_a;
	logic [20:0]              req_addr_b;
	logic                     ack_a;
	logic                     ack_b;

	slot_config cfg_i (
		.clk      (clk),
		.rst      (rst),
		.cfg_wr   (cfg_wr),
		.cfg_addr (cfg_addr),
		.cfg_data (cfg_data),
		.mapper_a (mapper_a),
		.mapper_b (mapper_b),
		.rom_en_a (rom_en_a),
		.rom_en_b (rom_en_b)
	);

	// Slot 1
	cart_mapper cart_a (
		.clk        (clk),
		.clk_en     (clk_en),
		.rst        (rst),
		.addr       (addr),
		.d_from_cpu (d_from_cpu),
		.rd_n       (rd_n),
		.wr_n       (wr_n),
		.sltsl_n    (sltsl_n[1]),
		.mapper     (mapper_a),
		.rom_en     (rom_en_a),
		.d_to_cpu   (d_a),
		.wait_req   (wait_a),
		.req        (req_a),
		.req_addr   (req_addr_a),
		.ack        (ack_a),
		.data       (mem_data)
	);

	// Slot 2
	cart_mapper cart_b (
		.clk        (clk),
		.clk_en     (clk_en),
		.rst        (rst),
		.addr       (addr),
		.d_from_cpu (d_from_cpu),
		.rd_n       (rd_n),
		.wr_n       (wr_n),
		.sltsl_n    (sltsl_n[2]),
		.mapper     (mapper_b),
		.rom_en     (rom_en_b),
		.d_to_cpu   (d_b),
		.wait_req   (wait_b),
		.req        (req_b),
		.req_addr   (req_addr_b),
		.ack        (ack_b),
		.data       (mem_data)
	);

	slot_router router_i (
		.clk        (clk),
		.rst        (rst),
		.sltsl_n    (sltsl_n),
		.d_a        (d_a),
		.d_b        (d_b),
		.d_ram      (d_ram),
		.wait_a     (wait_a),
		.wait_b     (wait_b),
		.req_a      (req_a),
		.req_b      (req_b),
		.req_addr_a (req_addr_a),
		.req_addr_b (req_addr_b),
		.ack_a      (ack_a),
		.ack_b      (ack_b),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_ack    (mem_ack),
		.d_to_cpu   (d_to_cpu),
		.cpu_wait   (cpu_wait)
	);

	// Slot 3 internal RAM
	main_ram #(
		.ram_addr_width (ram_addr_width)
	) ram_i (
		.clk        (clk),
		.clk_en     (clk_en),
		.addr       (addr),
		.d_from_cpu (d_from_cpu),
		.we         (!wr_n && !sltsl_n[3]),
		.q          (d_ram)
	);

endmodule

//--- dv/ext_mem_model.sv
`timescale 1ns/1ns

module ext_mem_model (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     mem_req,
	input  msx_slots_pkg::mem_addr_t mem_addr,
	output logic                     mem_ack,
	output msx_slots_pkg::cpu_data_t mem_data,
	output logic                     protocol_error
);

	msx_slots_pkg::mem_addr_t held_addr;
	int unsigned              delay;

	// Preloaded cartridge image, computed from every address bit
	function automatic msx_slots_pkg::cpu_data_t rom_byte(input msx_slots_pkg::mem_addr_t a);
		msx_slots_pkg::cpu_data_t folded;
		folded = a[15:8] + {2'b00, a[21:16]};
		return (a[7:0] * 8'd7) + folded;
	endfunction

	task automatic flag_error(input string what);
		$display("External memory: %s at %0t", what, $time);
		protocol_error <= 1'b1;
	endtask

	task automatic watch_request(input logic must_hold);
		if (must_hold && !mem_req)
			flag_error("mem_req dropped before mem_ack was raised");
		if (mem_addr !== held_addr)
			flag_error("mem_addr changed while a request was pending");
	endtask

	initial begin
		mem_ack <= 1'b0;
		mem_data <= 8'h00;
		protocol_error <= 1'b0;
		forever begin
			@(posedge clk);
			if (!rst && mem_req) begin
				held_addr = mem_addr;
				delay = $urandom_range(7, 0);
				repeat (delay) begin
					@(posedge clk);
					watch_request(1'b1);
				end
				mem_data <= rom_byte(held_addr);
				mem_ack <= 1'b1;
				// Ack stays up until the requester lets go
				do begin
					@(posedge clk);
					watch_request(1'b0);
				end while (mem_req);
				mem_ack <= 1'b0;
			end
		end
	end

endmodule

//--- dv/msx_slots_tb.sv
`timescale 1ns/1ns

module msx_slots_tb;

	// About 400 reads at up to 30 cycles each with margin
	localparam int max_cycles = 20000;

	logic                     clk;
	logic                     clk_en;
	logic                     rst;
	msx_slots_pkg::cpu_addr_t addr;
	msx_slots_pkg::cpu_data_t d_from_cpu;
	logic                     rd_n;
	logic                     wr_n;
	logic [3:0]               sltsl_n;
	msx_slots_pkg::cpu_data_t d_to_cpu;
	logic                     cpu_wait;
	logic                     cfg_wr;
	logic [1:0]               cfg_addr;
	msx_slots_pkg::cpu_data_t cfg_data;
	logic                     mem_req;
	msx_slots_pkg::mem_addr_t mem_addr;
	logic                     mem_ack;
	msx_slots_pkg::cpu_data_t mem_data;
	logic                     mem_error;

	msx_slots_pkg::cpu_data_t shadow_ram [65536];
	msx_slots_pkg::bank_t     shadow_bank [2][4];
	logic                     shadow_ascii8 [2];
	logic                     shadow_rom_en [2];
	msx_slots_pkg::cpu_addr_t ram_written [$];
	string                    name_q [$];
	msx_slots_pkg::cpu_data_t got_q [$];
	msx_slots_pkg::cpu_data_t exp_q [$];
	logic                     no_req;
	int                       cycle_count = 0;

	msx_slots dut_i (
		.clk        (clk),
		.clk_en     (clk_en),
		.rst        (rst),
		.addr       (addr),
		.d_from_cpu (d_from_cpu),
		.rd_n       (rd_n),
		.wr_n       (wr_n),
		.sltsl_n    (sltsl_n),
		.d_to_cpu   (d_to_cpu),
		.cpu_wait   (cpu_wait),
		.cfg_wr     (cfg_wr),
		.cfg_addr   (cfg_addr),
		.cfg_data   (cfg_data),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_ack    (mem_ack),
		.mem_data   (mem_data)
	);

	ext_mem_model mem_i (
		.clk            (clk),
		.rst            (rst),
		.mem_req        (mem_req),
		.mem_addr       (mem_addr),
		.mem_ack        (mem_ack),
		.mem_data       (mem_data),
		.protocol_error (mem_error)
	);

	function automatic msx_slots_pkg::cpu_data_t image_byte(input msx_slots_pkg::mem_addr_t ma);
		return (ma[7:0] * 8'd7) + ma[15:8] + {2'b00, ma[21:16]};
	endfunction

	// Selected, enabled cartridge inside 0x4000 to 0xBFFF
	function automatic logic cart_hit(input msx_slots_pkg::cpu_addr_t a, input logic [3:0] sel_n);
		if (a < 16'h4000 || a > 16'hBFFF)
			return 1'b0;
		return (!sel_n[1] && shadow_rom_en[0]) || (!sel_n[2] && shadow_rom_en[1]);
	endfunction

	function automatic msx_slots_pkg::cpu_data_t expected_byte(input msx_slots_pkg::cpu_addr_t a,
		input logic [3:0] sel_n);
		logic                 s;
		logic [14:0]          offset;
		msx_slots_pkg::bank_t bank;
		if (!sel_n[3])
			return shadow_ram[a];
		if (!cart_hit(a, sel_n))
			return 8'hFF;
		s = sel_n[1];
		offset = 15'(a - 16'h4000);
		if (shadow_ascii8[s])
			bank = shadow_bank[s][offset[14:13]];
		else
			bank = {6'd0, offset[14:13]};
		return image_byte({s, bank, a[12:0]});
	endfunction

	function automatic msx_slots_pkg::cpu_addr_t random_addr(input int unsigned lo,
		input int unsigned hi);
		return msx_slots_pkg::cpu_addr_t'($urandom_range(hi, lo));
	endfunction

	function automatic msx_slots_pkg::cpu_data_t random_byte();
		return msx_slots_pkg::cpu_data_t'($urandom);
	endfunction

	task automatic check_value(input string name, input msx_slots_pkg::cpu_data_t got,
		input msx_slots_pkg::cpu_data_t exp_val);
		if (got !== exp_val) begin
			$display("ERR %0t %s got 0x%02h expected 0x%02h", $time, name, got, exp_val);
			$display("Verification failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic queue_sample(input string name, input msx_slots_pkg::cpu_data_t got,
		input msx_slots_pkg::cpu_data_t exp_val);
		name_q.push_back(name);
		got_q.push_back(got);
		exp_q.push_back(exp_val);
	endtask

	// Rising edge on which the DUT sees clk_en high
	task automatic next_cpu_edge();
		do
			@(posedge clk);
		while (!clk_en);
	endtask

	task automatic cpu_read(input msx_slots_pkg::cpu_addr_t a, input logic [3:0] sel_n);
		msx_slots_pkg::cpu_data_t exp_data;
		logic                     exp_wait;
		exp_data = expected_byte(a, sel_n);
		exp_wait = cart_hit(a, sel_n);
		next_cpu_edge();
		addr <= a;
		sltsl_n <= sel_n;
		rd_n <= 1'b0;
		next_cpu_edge();
		next_cpu_edge();
		queue_sample("cpu_wait", {7'd0, cpu_wait}, {7'd0, exp_wait});
		while (cpu_wait)
			next_cpu_edge();
		next_cpu_edge();
		queue_sample("d_to_cpu", d_to_cpu, exp_data);
		rd_n <= 1'b1;
		sltsl_n <= 4'hF;
	endtask

	task automatic cpu_write(input msx_slots_pkg::cpu_addr_t a, input msx_slots_pkg::cpu_data_t d,
		input logic [3:0] sel_n);
		logic s;
		next_cpu_edge();
		addr <= a;
		d_from_cpu <= d;
		sltsl_n <= sel_n;
		wr_n <= 1'b0;
		next_cpu_edge();
		wr_n <= 1'b1;
		sltsl_n <= 4'hF;
		s = sel_n[1];
		if (!sel_n[3])
			shadow_ram[a] = d;
		else if ((!sel_n[1] || !sel_n[2]) && a[15:13] == 3'b011 && shadow_ascii8[s])
			shadow_bank[s][a[12:11]] = d;
	endtask

	task automatic cfg_write(input logic [1:0] a, input msx_slots_pkg::cpu_data_t d);
		@(posedge clk);
		cfg_wr <= 1'b1;
		cfg_addr <= a;
		cfg_data <= d;
		@(posedge clk);
		cfg_wr <= 1'b0;
		if (a == 2'd2) begin
			shadow_rom_en[0] = d[0];
			shadow_rom_en[1] = d[1];
		end else if (a != 2'd3 && d < 8'd2) begin
			shadow_ascii8[a[0]] = d[0];
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		clk_en <= 1'b0;
		forever begin
			@(posedge clk);
			clk_en <= !clk_en;
		end
	end

	// Compares everything the bus driver sampled
	initial begin
		string                    name;
		msx_slots_pkg::cpu_data_t got;
		msx_slots_pkg::cpu_data_t exp_val;
		forever begin
			@(negedge clk);
			while (got_q.size() > 0) begin
				name = name_q.pop_front();
				got = got_q.pop_front();
				exp_val = exp_q.pop_front();
				check_value(name, got, exp_val);
			end
		end
	end

	always @(posedge clk) begin
		if (no_req && !rst)
			check_value("mem_req", {7'd0, mem_req}, 8'h00);
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Timeout: tests did not finish within %0d cycles", max_cycles);
			$display("Verification failed");
			$fatal(1, "timeout");
		end else if (mem_error) begin
			$display("Verification failed");
			$fatal(1, "external memory handshake broken");
		end
	end

	initial begin
		msx_slots_pkg::cpu_addr_t a;
		void'($urandom(58));
		rst <= 1'b1;
		addr <= '0;
		d_from_cpu <= '0;
		rd_n <= 1'b1;
		wr_n <= 1'b1;
		sltsl_n <= 4'hF;
		cfg_wr <= 1'b0;
		cfg_addr <= 2'd0;
		cfg_data <= '0;
		no_req <= 1'b0;
		for (int i = 0; i < 4; i++) begin
			shadow_bank[0][i] = msx_slots_pkg::bank_t'(i);
			shadow_bank[1][i] = msx_slots_pkg::bank_t'(i);
		end
		shadow_ascii8[0] = 1'b0;
		shadow_ascii8[1] = 1'b0;
		shadow_rom_en[0] = 1'b1;
		shadow_rom_en[1] = 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		next_cpu_edge();
		queue_sample("cpu_wait", {7'd0, cpu_wait}, 8'h00);
		queue_sample("mem_req", {7'd0, mem_req}, 8'h00);
		for (int i = 0; i < 4; i++)
			cpu_read(random_addr('h0000, 'hFFFF), 4'b1110);

		// Internal RAM in slot 3
		no_req <= 1'b1;
		for (int i = 0; i < 100; i++) begin
			a = random_addr('h0000, 'hFFFF);
			cpu_write(a, random_byte(), 4'b0111);
			ram_written.push_back(a);
		end
		for (int i = 0; i < 100; i++)
			cpu_read(ram_written[$urandom_range(ram_written.size() - 1, 0)], 4'b0111);
		no_req <= 1'b0;

		// Slot 1 with the plain 32 kB mapper
		for (int i = 0; i < 100; i++)
			cpu_read(random_addr('h4000, 'hBFFF), 4'b1101);
		no_req <= 1'b1;
		for (int i = 0; i < 20; i++) begin
			if ($urandom_range(1, 0) == 0)
				cpu_read(random_addr('h0000, 'h3FFF), 4'b1101);
			else
				cpu_read(random_addr('hC000, 'hFFFF), 4'b1101);
		end
		no_req <= 1'b0;

		// Slot 2 in ASCII8 mode with bank switching
		cfg_write(2'd1, 8'h01);
		for (int round = 0; round < 2; round++) begin
			for (int i = 0; i < 8; i++)
				cpu_write(random_addr('h6000, 'h7FFF), random_byte(), 4'b1011);
			for (int i = 0; i < 50; i++)
				cpu_read(random_addr('h4000, 'hBFFF), 4'b1011);
		end

		// Disabled ROMs
		cfg_write(2'd2, 8'h02);
		no_req <= 1'b1;
		for (int i = 0; i < 20; i++)
			cpu_read(random_addr('h4000, 'hBFFF), 4'b1101);
		cfg_write(2'd2, 8'h01);
		for (int i = 0; i < 20; i++)
			cpu_read(random_addr('h4000, 'hBFFF), 4'b1011);
		no_req <= 1'b0;
		cfg_write(2'd2, 8'h03);
		for (int i = 0; i < 10; i++) begin
			cpu_read(random_addr('h4000, 'hBFFF), 4'b1101);
			cpu_read(random_addr('h4000, 'hBFFF), 4'b1011);
		end

		repeat (4) @(posedge clk);
		$display("Verification passed");
		$finish;
	end

endmodule

//--- msx_slots.f
design/msx_slots_pkg.sv
design/slot_config.sv
design/cart_mapper.sv
design/slot_router.sv
design/main_ram.sv
design/msx_slots.sv
dv/ext_mem_model.sv
dv/msx_slots_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = msx_slots_tb
FILELIST  = msx_slots.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
PASS_MSG  = Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
